// ==== include/addressMap.svh ====
`ifndef ADDRESSMAP_SVH
`define ADDRESSMAP_SVH

// The CIC decimator register space holds two 32-bit words starting at the base
`define CICDECBASE 12'h200

// The upper nine address bits select the space and bits 2:0 address inside it
`define CICDECMASK 12'hff8

`endif

// ==== logic/cicPkg.sv ====
package cicPkg;

    localparam int sampleWidth = 18;
    localparam int accWidth = 48;
    localparam int decimationWidth = 10;
    localparam int shiftWidth = 5;
    localparam int busAddrWidth = 12;
    localparam int busDataWidth = 32;

    typedef logic signed [sampleWidth-1:0] sample_t;
    typedef logic signed [accWidth-1:0] acc_t;

    // Rate divides by this value plus one
    typedef logic [decimationWidth-1:0] decimation_t;
    typedef logic [shiftWidth-1:0] shift_t;

    typedef logic [busAddrWidth-1:0] busAddr_t;
    typedef logic [busDataWidth-1:0] busData_t;

    // Word offset inside the register space is taken from addr bits 3:2
    typedef enum logic [1:0] {
        regDecimation = 2'd0,
        regShift = 2'd1
    } cicRegOffset_e;

endpackage

// ==== logic/cicRegs.sv ====
`timescale 1ns/1ps

module cicRegs import cicPkg::*; #(
    parameter decimation_t ResetDecimation = 10'd7,
    parameter shift_t ResetShift = 5'd0
) (
    input  logic clk,
    input  logic reset,
    input  logic cs,
    input  busAddr_t addr,
    input  busData_t dataIn,
    input  logic wr0,
    input  logic wr1,
    input  logic wr2,
    input  logic wr3,
    output busData_t dataOut,
    output decimation_t cicDecimation,
    output shift_t cicShift
);

    cicRegOffset_e offset;
    logic [3:0] strobes;
    busData_t decMerged;
    busData_t shiftMerged;

    // Replace each byte whose strobe is high, keep the rest
    function automatic busData_t mergeLanes(busData_t current, busData_t data,
                                            logic [3:0] lanes);
        busData_t merged;
        merged = current;
        for (int lane = 0; lane < 4; lane++) begin
            if (lanes[lane])
                merged[lane*8 +: 8] = data[lane*8 +: 8];
        end
        return merged;
    endfunction

    assign offset = cicRegOffset_e'(addr[3:2]);
    assign strobes = {wr3, wr2, wr1, wr0};

    assign decMerged = mergeLanes(busData_t'(cicDecimation), dataIn, strobes);
    assign shiftMerged = mergeLanes(busData_t'(cicShift), dataIn, strobes);

    always_ff @(posedge clk) begin
        if (reset) begin
            cicDecimation <= ResetDecimation;
            cicShift <= ResetShift;
        end else if (cs) begin
            if (offset == regDecimation)
                cicDecimation <= decMerged[decimationWidth-1:0];
            if (offset == regShift)
                cicShift <= shiftMerged[shiftWidth-1:0];
        end
    end

    always_comb begin
        dataOut = '0; // Outside the space and unused bits read zero
        if (cs) begin
            case (offset)
                regDecimation: dataOut = busData_t'(cicDecimation);
                regShift:      dataOut = busData_t'(cicShift);
                default:       dataOut = '0;
            endcase
        end
    end

endmodule

// ==== logic/inputShifter.sv ====
`timescale 1ns/1ps

module inputShifter import cicPkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic sync,
    input  shift_t shift,
    input  sample_t din,
    output acc_t dout
);

    acc_t extended;

    // Sign bit copied into the upper accumulator bits
    assign extended = {{(accWidth-sampleWidth){din[sampleWidth-1]}}, din};

    always_ff @(posedge clk) begin
        if (reset) begin
            dout <= '0;
        end else if (sync) begin
            dout <= extended <<< shift; // Wraps if the shift pushes bits off the top
        end
    end

endmodule

// ==== logic/cicIntegrator.sv ====
`timescale 1ns/1ps

module cicIntegrator import cicPkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic sync,
    input  acc_t din,
    output acc_t dout
);

    acc_t stage0;
    acc_t stage1;
    acc_t stage2;

    // All three stages step together from their pre-edge values
    always_ff @(posedge clk) begin
        if (reset) begin
            stage0 <= '0;
            stage1 <= '0;
            stage2 <= '0;
        end else if (sync) begin
            stage0 <= stage0 + din;
            stage1 <= stage1 + stage0;
            stage2 <= stage2 + stage1;
        end
    end

    assign dout = stage2;

endmodule

// ==== logic/cicComb.sv ====
`timescale 1ns/1ps

module cicComb import cicPkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic syncOut,
    input  acc_t din,
    output acc_t dout
);

    localparam int tapWidth = accWidth + 1;

    logic signed [tapWidth-1:0] yExt;
    logic signed [tapWidth-1:0] y3;
    logic signed [tapWidth-1:0] sum3;
    logic signed [tapWidth-1:0] tap0;
    logic signed [tapWidth-1:0] tap1;
    logic signed [tapWidth-1:0] tap2;
    acc_t tap3;

    // FIR form of (1 - z^-1)^3 = 1 - 3z^-1 + 3z^-2 - z^-3 with one clock of delay
    assign yExt = {din[accWidth-1], din};
    assign y3 = yExt + {din, 1'b0}; // y plus 2y
    assign sum3 = tap2 + yExt;

    always_ff @(posedge clk) begin
        if (reset) begin
            tap0 <= '0;
            tap1 <= '0;
            tap2 <= '0;
            tap3 <= '0;
        end else if (syncOut) begin
            tap0 <= yExt;
            tap1 <= y3 - tap0;
            tap2 <= tap1 - y3;
            tap3 <= sum3[accWidth-1:0];
        end
    end

    assign dout = tap3;

endmodule

// ==== logic/cicDecimator.sv ====
`timescale 1ns/1ps
`include "addressMap.svh"

module cicDecimator import cicPkg::*; #(
    parameter decimation_t ResetDecimation = 10'd7,
    parameter shift_t ResetShift = 5'd0
) (
    input  logic clk,
    input  logic reset,
    input  logic sync,
    input  logic wr0,
    input  logic wr1,
    input  logic wr2,
    input  logic wr3,
    input  busAddr_t addr,
    input  busData_t din,
    output busData_t dout,
    input  sample_t inI,
    input  sample_t inQ,
    output acc_t outI,
    output acc_t outQ,
    output logic syncOut
);

    logic cs;
    decimation_t cicDecimation;
    shift_t cicShift;
    decimation_t decCount;
    acc_t shiftI;
    acc_t shiftQ;
    acc_t accI;
    acc_t accQ;

    assign cs = ((addr & `CICDECMASK) == `CICDECBASE);

    cicRegs #(
        .ResetDecimation(ResetDecimation),
        .ResetShift(ResetShift)
    ) regs (
        .clk(clk),
        .reset(reset),
        .cs(cs),
        .addr(addr),
        .dataIn(din),
        .wr0(wr0),
        .wr1(wr1),
        .wr2(wr2),
        .wr3(wr3),
        .dataOut(dout),
        .cicDecimation(cicDecimation),
        .cicShift(cicShift)
    );

    // Counter starts at one so the first output follows the second sync
    always_ff @(posedge clk) begin
        if (reset) begin
            decCount <= decimation_t'(1);
            syncOut <= 1'b0;
        end else begin
            syncOut <= sync && (decCount == '0);
            if (sync) begin
                if (decCount == '0)
                    decCount <= cicDecimation; // New decimation is picked up here
                else
                    decCount <= decCount - 1'b1;
            end
        end
    end

    inputShifter iShifter (
        .clk(clk), .reset(reset), .sync(sync),
        .shift(cicShift), .din(inI), .dout(shiftI)
    );

    inputShifter qShifter (
        .clk(clk), .reset(reset), .sync(sync),
        .shift(cicShift), .din(inQ), .dout(shiftQ)
    );

    cicIntegrator iIntegrator (
        .clk(clk), .reset(reset), .sync(sync),
        .din(shiftI), .dout(accI)
    );

    cicIntegrator qIntegrator (
        .clk(clk), .reset(reset), .sync(sync),
        .din(shiftQ), .dout(accQ)
    );

    // Combs run at the decimated rate
    cicComb iComb (
        .clk(clk), .reset(reset), .syncOut(syncOut),
        .din(accI), .dout(outI)
    );

    cicComb qComb (
        .clk(clk), .reset(reset), .syncOut(syncOut),
        .din(accQ), .dout(outQ)
    );

endmodule

// ==== verification/cicDecimator_chk.sv ====
`timescale 1ns/1ps

module cicDecimator_chk import cicPkg::*; (
    input logic clk,
    input logic reset,
    input logic sync,
    input logic syncOut,
    input acc_t outI,
    input acc_t outQ
);

    pulseSingle: assert property (@(posedge clk) disable iff (reset) syncOut |=> !syncOut)
        else $error("syncOut high on two consecutive clocks");

    // An output strobe needs a sync on the clock before
    pulseAfterSync: assert property (@(posedge clk) disable iff (reset)
        syncOut |-> $past(sync) && !$past(reset))
        else $error("syncOut high without a preceding sync");

    outputsHold: assert property (@(posedge clk) disable iff (reset)
        (outI != $past(outI) || outQ != $past(outQ)) |-> $past(syncOut))
        else $error("Outputs changed without a preceding syncOut");

    quietInReset: assert property (@(posedge clk) reset |=> !syncOut)
        else $error("syncOut high after a reset clock");

endmodule

bind cicDecimator cicDecimator_chk chk (
    .clk(clk), .reset(reset), .sync(sync),
    .syncOut(syncOut), .outI(outI), .outQ(outQ)
);

// ==== verification/cicTb.sv ====
`timescale 1ns/1ps
`include "addressMap.svh"

module cicTb import cicPkg::*; ;

    localparam int rateSamples = 40;
    localparam int dcSamples = 2 + 7 * 8; // Eighth output at the largest tested decimation
    localparam int randSamples = 60;
    localparam int shiftSamples = 20;
    localparam int maxGap = 3;
    localparam int totalSamples = 3 * rateSamples + 2 * dcSamples + randSamples
                                  + 3 * shiftSamples;
    localparam int timeoutCycles = 4 * totalSamples * maxGap;

    logic clk;
    logic reset;
    logic sync;
    logic wr0;
    logic wr1;
    logic wr2;
    logic wr3;
    busAddr_t addr;
    busData_t din;
    busData_t dout;
    sample_t inI;
    sample_t inQ;
    acc_t outI;
    acc_t outQ;
    logic syncOut;

    logic [31:0] lfsrState;
    int cycleCount;
    logic lastPulse;
    acc_t gotI;
    acc_t gotQ;

    // Reference model state with index 0 for I and index 1 for Q
    acc_t mShifted[2];
    acc_t mInt0[2];
    acc_t mInt1[2];
    acc_t mInt2[2];
    acc_t mHist[2][3];
    acc_t expOut[2];
    decimation_t mCount;
    decimation_t mDecimation;
    shift_t mShiftAmount;

    cicDecimator uut (
        .clk(clk), .reset(reset), .sync(sync),
        .wr0(wr0), .wr1(wr1), .wr2(wr2), .wr3(wr3),
        .addr(addr), .din(din), .dout(dout),
        .inI(inI), .inQ(inQ), .outI(outI), .outQ(outQ), .syncOut(syncOut)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsrNext(logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic drawBits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsrNext(lfsrState);
            value = {value[30:0], lfsrState[0]};
        end
    endtask

    task automatic stopRun();
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic compareData(input string name, input busData_t got, input busData_t want);
        if (got !== want) begin
            $display("** Error: %s got %h expected %h", name, got, want);
            stopRun();
        end
    endtask

    task automatic compareAcc(input string name, input acc_t got, input acc_t want);
        if (got !== want) begin
            $display("** Error: %s got %h expected %h", name, got, want);
            stopRun();
        end
    endtask

    task automatic compareBit(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("** Error: %s got %h expected %h", name, got, want);
            stopRun();
        end
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount > timeoutCycles) begin
            $display("Timeout: the tests did not finish within %0d clock cycles", timeoutCycles);
            stopRun();
        end
    end

    task automatic modelReset();
        for (int ch = 0; ch < 2; ch++) begin
            mShifted[ch] = '0;
            mInt0[ch] = '0;
            mInt1[ch] = '0;
            mInt2[ch] = '0;
            for (int t = 0; t < 3; t++)
                mHist[ch][t] = '0;
        end
        mCount = decimation_t'(1);
        mDecimation = 10'd7;
        mShiftAmount = 5'd0;
    endtask

    task automatic applyReset();
        reset <= 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        modelReset();
    endtask

    // One sync edge of the model with every stage updated from its pre-edge value
    task automatic modelSync(input sample_t xi, input sample_t xq, output logic pulse);
        sample_t x[2];
        acc_t y;
        x[0] = xi;
        x[1] = xq;
        pulse = (mCount == '0);
        if (pulse)
            mCount = mDecimation;
        else
            mCount = mCount - decimation_t'(1);
        for (int ch = 0; ch < 2; ch++) begin
            mInt2[ch] = mInt2[ch] + mInt1[ch];
            mInt1[ch] = mInt1[ch] + mInt0[ch];
            mInt0[ch] = mInt0[ch] + mShifted[ch];
            mShifted[ch] = acc_t'(x[ch]) <<< mShiftAmount;
            if (pulse) begin
                y = mInt2[ch];
                expOut[ch] = y - acc_t'(3) * mHist[ch][0] + acc_t'(3) * mHist[ch][1]
                             - mHist[ch][2]; // Third difference of decimated values
                mHist[ch][2] = mHist[ch][1];
                mHist[ch][1] = mHist[ch][0];
                mHist[ch][0] = y;
            end
        end
    endtask

    task automatic busWrite(input busAddr_t a, input busData_t d, input logic [3:0] lanes);
        addr <= a;
        din <= d;
        {wr3, wr2, wr1, wr0} <= lanes;
        @(posedge clk);
        {wr3, wr2, wr1, wr0} <= 4'b0000;
    endtask

    task automatic busRead(input busAddr_t a, input busData_t want);
        addr <= a;
        @(negedge clk);
        compareData("dout", dout, want);
        @(posedge clk);
    endtask

    task automatic setDecimation(input decimation_t d);
        busWrite(`CICDECBASE, busData_t'(d), 4'b1111);
        mDecimation = d;
    endtask

    task automatic setShift(input shift_t s);
        busWrite(`CICDECBASE + 12'h4, busData_t'(s), 4'b1111);
        mShiftAmount = s;
    endtask

    task automatic sendSample(input sample_t xi, input sample_t xq);
        logic wantPulse;
        logic [31:0] gap;
        sync <= 1'b1;
        inI <= xi;
        inQ <= xq;
        @(posedge clk);
        sync <= 1'b0;
        modelSync(xi, xq, wantPulse);
        @(negedge clk);
        lastPulse = syncOut;
        compareBit("syncOut", syncOut, wantPulse);
        if (wantPulse) begin
            @(negedge clk); // Combs have advanced on the clock after the pulse
            gotI = outI;
            gotQ = outQ;
            compareAcc("outI", outI, expOut[0]);
            compareAcc("outQ", outQ, expOut[1]);
        end
        drawBits(2, gap);
        repeat (gap) begin
            @(negedge clk);
            compareBit("syncOut", syncOut, 1'b0);
        end
        @(posedge clk);
    endtask

    task automatic testResetReadback();
        busRead(`CICDECBASE, 32'h0000_0007);
        busRead(`CICDECBASE + 12'h4, 32'h0000_0000);
        busRead(12'h100, 32'h0000_0000);
        busRead(`CICDECBASE + 12'h8, 32'h0000_0000);
    endtask

    task automatic testByteLanes();
        busWrite(`CICDECBASE, 32'hffff_ffff, 4'b1111);
        busRead(`CICDECBASE, 32'h0000_03ff);
        busWrite(`CICDECBASE, 32'h0000_0005, 4'b0001);
        busRead(`CICDECBASE, 32'h0000_0305);
        busWrite(`CICDECBASE, 32'h0000_0100, 4'b0010);
        busRead(`CICDECBASE, 32'h0000_0105);
        busWrite(`CICDECBASE + 12'h4, 32'hffff_ff00, 4'b1110);
        busRead(`CICDECBASE + 12'h4, 32'h0000_0000);
        busWrite(`CICDECBASE + 12'h4, 32'hdead_be13, 4'b0001);
        busRead(`CICDECBASE + 12'h4, 32'h0000_0013);
        busWrite(12'h100, 32'h0000_0000, 4'b1111); // Writes outside the space have no effect
        busRead(`CICDECBASE, 32'h0000_0105);
    endtask

    task automatic testDecimationRate();
        decimation_t rates[3] = '{10'd0, 10'd3, 10'd7};
        logic wanted;
        foreach (rates[r]) begin
            applyReset();
            setDecimation(rates[r]);
            for (int k = 1; k <= rateSamples; k++) begin
                sendSample(sample_t'(k), -sample_t'(k));
                wanted = (k >= 2) && ((k - 2) % (int'(rates[r]) + 1) == 0);
                compareBit("syncOut pulse count", lastPulse, wanted);
            end
        end
    endtask

    task automatic checkDcGain(input decimation_t d, input shift_t s, input sample_t xi,
                               input sample_t xq);
        int pulses;
        int ratio;
        acc_t wantI;
        acc_t wantQ;
        applyReset();
        setDecimation(d);
        setShift(s);
        ratio = int'(d) + 1;
        wantI = (acc_t'(xi) <<< s) * acc_t'(ratio * ratio * ratio);
        wantQ = (acc_t'(xq) <<< s) * acc_t'(ratio * ratio * ratio);
        pulses = 0;
        while (pulses < 8) begin
            sendSample(xi, xq);
            if (lastPulse) begin
                pulses++;
                if (pulses > 4) begin
                    compareAcc("outI", gotI, wantI);
                    compareAcc("outQ", gotQ, wantQ);
                end
            end
        end
    endtask

    task automatic testRandomSamples();
        logic [31:0] bitsI;
        logic [31:0] bitsQ;
        applyReset();
        setDecimation(10'd4);
        setShift(5'd3);
        repeat (randSamples) begin
            drawBits(18, bitsI);
            drawBits(18, bitsQ);
            sendSample(sample_t'(bitsI), sample_t'(bitsQ));
        end
    endtask

    task automatic testShiftChange();
        shift_t shifts[3] = '{5'd1, 5'd17, 5'd0};
        logic [31:0] bitsI;
        logic [31:0] bitsQ;
        applyReset();
        setDecimation(10'd2);
        foreach (shifts[i]) begin
            setShift(shifts[i]);
            repeat (shiftSamples) begin
                drawBits(18, bitsI);
                drawBits(18, bitsQ);
                sendSample(sample_t'(bitsI), sample_t'(bitsQ));
            end
        end
    endtask

    initial begin
        reset = 1'b1;
        sync = 1'b0;
        wr0 = 1'b0;
        wr1 = 1'b0;
        wr2 = 1'b0;
        wr3 = 1'b0;
        addr = '0;
        din = '0;
        inI = '0;
        inQ = '0;
        cycleCount = 0;
        lastPulse = 1'b0;
        lfsrState = 32'h612b1c0d;
        applyReset();
        testResetReadback();
        testByteLanes();
        testDecimationRate();
        checkDcGain(10'd3, 5'd2, 18'sd1000, -18'sd517);
        checkDcGain(10'd7, 5'd0, -18'sd131072, 18'sd131071);
        testRandomSamples();
        testShiftChange();
        $display("TEST OK");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+include
logic/cicPkg.sv
logic/cicRegs.sv
logic/inputShifter.sv
logic/cicIntegrator.sv
logic/cicComb.sv
logic/cicDecimator.sv
verification/cicDecimator_chk.sv
verification/cicTb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the CIC decimator testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module cicTb -o cicTbSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/cicTbSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "^TEST OK$" sim.log; then
    exit 0
fi
echo "Pass message missing from sim.log"
exit 1
